// File: hw/pkg_dtypes.sv
`default_nettype none

package pkg_dtypes;

  // ####################
  // widths
  // ####################
  localparam int WORD_WIDTH     = 16;
  localparam int INSTR_WIDTH    = 16;
  localparam int REG_ADDR_WIDTH = 3;

  localparam int OPCODE_WIDTH = 5;
  localparam int IMM_FLAG_BIT = 4; // opcode bit that marks the immediate form.
  localparam int IMM_WIDTH    = INSTR_WIDTH - OPCODE_WIDTH - 2 * REG_ADDR_WIDTH;
  localparam int SPARE_WIDTH  = INSTR_WIDTH - OPCODE_WIDTH - 3 * REG_ADDR_WIDTH;

  // ####################
  // opcodes
  // ####################
  // the low four bits pick the operation and bit 4 selects the immediate form.
  typedef enum logic [OPCODE_WIDTH-1:0] {
    NOT    = 5'h00, AND    = 5'h01, OR     = 5'h02, XOR    = 5'h03,
    ADD    = 5'h04, SUB    = 5'h05, NAND   = 5'h06, NOR    = 5'h07,
    XNOR   = 5'h08, LSH    = 5'h09, RSH    = 5'h0a, LRO    = 5'h0b,
    RRO    = 5'h0c,
    NOT_I  = 5'h10, AND_I  = 5'h11, OR_I   = 5'h12, XOR_I  = 5'h13,
    ADD_I  = 5'h14, SUB_I  = 5'h15, NAND_I = 5'h16, NOR_I  = 5'h17,
    XNOR_I = 5'h18, LSH_I  = 5'h19, RSH_I  = 5'h1a, LRO_I  = 5'h1b,
    RRO_I  = 5'h1c
  } enum_instr_exec_unit;

  // one instruction word, seen as either the register or the immediate layout.
  typedef union packed {
    struct packed {
      logic [OPCODE_WIDTH-1:0]   opcode;
      logic [REG_ADDR_WIDTH-1:0] rd;
      logic [REG_ADDR_WIDTH-1:0] rs0;
      logic [REG_ADDR_WIDTH-1:0] rs1;
      logic [SPARE_WIDTH-1:0]    spare;
    } reg_form;
    struct packed {
      logic [OPCODE_WIDTH-1:0]   opcode;
      logic [REG_ADDR_WIDTH-1:0] rd;
      logic [REG_ADDR_WIDTH-1:0] rs0;
      logic [IMM_WIDTH-1:0]      imm;  // zero-extended to the data width.
    } imm_form;
  } type_iqueue_opcode;

  // decoded control word for the datapath.
  typedef struct packed {
    logic invert_b;
    logic carry_in_one;
    logic sel_and;
    logic sel_or;
    logic sel_xor;
    logic sel_sum;
    logic invert_out;
    logic sel_shift;
  } type_alu_ctrl;

endpackage

`default_nettype wire

// File: hw/instr_queue.sv
`timescale 1ns/1ps
`default_nettype none

module instr_queue import pkg_dtypes::*; #(
  parameter int QUEUE_DEPTH = 4
) (
  input  wire                    clk,
  input  wire                    reset_i,

  input  wire                    push_i,
  input  wire type_iqueue_opcode instr_i,

  input  wire                    pop_i,
  output type_iqueue_opcode      head_instr_o,

  output logic                   empty_o,
  output logic                   full_o
);

  localparam int PTR_WIDTH = $clog2(QUEUE_DEPTH);

  type_iqueue_opcode mem [QUEUE_DEPTH];

  logic [PTR_WIDTH-1:0] wr_ptr;
  logic [PTR_WIDTH-1:0] rd_ptr;
  logic [PTR_WIDTH:0]   count;
  logic                 do_push;
  logic                 do_pop;

  // full is taken from the count before this cycle's pop frees a slot.
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  assign empty_o = (count == '0);
  assign full_o  = (count == (PTR_WIDTH + 1)'(QUEUE_DEPTH));

  assign head_instr_o = mem[rd_ptr]; // show-ahead, the head is always visible.

  // ####################
  // storage
  // ####################
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= instr_i;
    end
  end

  // ####################
  // pointers and count
  // ####################
  always_ff @(posedge clk) begin
    if (reset_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1; // depth is a power of two so the pointer wraps by itself.
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // both or neither leave the occupancy alone.
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file import pkg_dtypes::*; #(
  parameter int DATA_WIDTH = WORD_WIDTH
) (
  input  wire                      clk,
  input  wire                      reset_i,

  input  wire [REG_ADDR_WIDTH-1:0] rs0_addr_i,
  input  wire [REG_ADDR_WIDTH-1:0] rs1_addr_i,
  output logic [DATA_WIDTH-1:0]    rs0_data_o,
  output logic [DATA_WIDTH-1:0]    rs1_data_o,

  input  wire                      wr_valid_i,
  input  wire [REG_ADDR_WIDTH-1:0] wr_addr_i,
  input  wire [DATA_WIDTH-1:0]     wr_data_i,

  input  wire                      wb_ready_i,
  output logic                     store_success_o
);

  localparam int NUM_REGS = 2 ** REG_ADDR_WIDTH;

  logic [DATA_WIDTH-1:0] regs [NUM_REGS];

  // a write only lands when the retire sink takes the result in the same cycle.
  assign store_success_o = wr_valid_i & wb_ready_i;

  // Both read ports are combinational.
  assign rs0_data_o = regs[rs0_addr_i];
  assign rs1_data_o = regs[rs1_addr_i];

  // ####################
  // write port
  // ####################
  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0; // the file starts out all zero.
      end
    end else if (store_success_o) begin
      regs[wr_addr_i] <= wr_data_i;
    end
  end

endmodule

`default_nettype wire

// File: hw/alu_comb.sv
`timescale 1ns/1ps
`default_nettype none

module alu_comb import pkg_dtypes::*; #(
  parameter int DATA_WIDTH = WORD_WIDTH
) (
  input  wire [DATA_WIDTH-1:0]  a_i,
  input  wire [DATA_WIDTH-1:0]  b_i,
  input  wire [3:0]             shamt_i,
  input  wire                   shift_left_i,
  input  wire                   shift_rotate_i,
  input  wire type_alu_ctrl     ctrl_i,
  output logic [DATA_WIDTH-1:0] out_o,
  output logic                  cout_o
);

  logic [DATA_WIDTH-1:0]   b_eff;
  logic [DATA_WIDTH-1:0]   sum;
  logic [DATA_WIDTH-1:0]   logic_res;
  logic [DATA_WIDTH-1:0]   shift_res;
  logic [2*DATA_WIDTH-1:0] rot_left;
  logic [2*DATA_WIDTH-1:0] rot_right;

  assign b_eff = ctrl_i.invert_b ? ~b_i : b_i;

  // adder with its carry out kept as a spare flag.
  assign {cout_o, sum} = {1'b0, a_i} + {1'b0, b_eff} + (DATA_WIDTH + 1)'(ctrl_i.carry_in_one);

  // every selected result is ORed in, then the whole thing may be inverted.
  always_comb begin
    logic_res = ({DATA_WIDTH{ctrl_i.sel_and}} & (a_i & b_eff))
              | ({DATA_WIDTH{ctrl_i.sel_or}}  & (a_i | b_eff))
              | ({DATA_WIDTH{ctrl_i.sel_xor}} & (a_i ^ b_eff))
              | ({DATA_WIDTH{ctrl_i.sel_sum}} & sum);
    if (ctrl_i.invert_out) begin
      logic_res = ~logic_res;
    end
  end

  // ####################
  // barrel shifter
  // ####################
  // Rotates shift a doubled copy of the word and keep the half that wrapped around.
  assign rot_left  = {a_i, a_i} << shamt_i;
  assign rot_right = {a_i, a_i} >> shamt_i;

  always_comb begin
    case ({shift_left_i, shift_rotate_i})
      2'b00:   shift_res = a_i >> shamt_i;
      2'b01:   shift_res = rot_right[DATA_WIDTH-1:0];
      2'b10:   shift_res = a_i << shamt_i;
      default: shift_res = rot_left[2*DATA_WIDTH-1:DATA_WIDTH];
    endcase
  end

  assign out_o = ctrl_i.sel_shift ? shift_res : logic_res;

endmodule

`default_nettype wire

// File: hw/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import pkg_dtypes::*; #(
  parameter int DATA_WIDTH = WORD_WIDTH
) (
  input  wire type_iqueue_opcode    head_instr_i,
  input  wire                       queue_empty_i,

  output logic [REG_ADDR_WIDTH-1:0] rs0_addr_o,
  output logic [REG_ADDR_WIDTH-1:0] rs1_addr_o,
  input  wire [DATA_WIDTH-1:0]      rs0_data_i,
  input  wire [DATA_WIDTH-1:0]      rs1_data_i,

  output logic                      wr_valid_o,
  output logic [REG_ADDR_WIDTH-1:0] wr_addr_o,
  output logic [DATA_WIDTH-1:0]     wr_data_o,

  input  wire                       store_success_i,
  output logic                      pop_o
);

  enum_instr_exec_unit   op_base;
  type_alu_ctrl          ctrl;
  logic                  is_imm;
  logic                  shift_left;
  logic                  shift_rotate;
  logic [DATA_WIDTH-1:0] imm_ext;
  logic [DATA_WIDTH-1:0] opd_b;

  // bit 4 of the opcode says which layout the rest of the word uses.
  assign is_imm  = head_instr_i.reg_form.opcode[IMM_FLAG_BIT];
  assign op_base = enum_instr_exec_unit'({1'b0, head_instr_i.reg_form.opcode[3:0]});

  // ####################
  // instruction decode
  // ####################
  // the control bits run from invert_b at the top down to sel_shift at the bottom.
  always_comb begin
    case (op_base)
      NOT:     ctrl = type_alu_ctrl'(8'b00_0100_1_0); // ~(a | 0).
      AND:     ctrl = type_alu_ctrl'(8'b00_1000_0_0);
      OR:      ctrl = type_alu_ctrl'(8'b00_0100_0_0);
      XOR:     ctrl = type_alu_ctrl'(8'b00_0010_0_0);
      ADD:     ctrl = type_alu_ctrl'(8'b00_0001_0_0);
      SUB:     ctrl = type_alu_ctrl'(8'b11_0001_0_0); // a + ~b + 1.
      NAND:    ctrl = type_alu_ctrl'(8'b00_1000_1_0);
      NOR:     ctrl = type_alu_ctrl'(8'b00_0100_1_0);
      XNOR:    ctrl = type_alu_ctrl'(8'b00_0010_1_0);
      LSH, RSH, LRO, RRO: ctrl = type_alu_ctrl'(8'b00_0000_0_1);
      default: ctrl = type_alu_ctrl'(8'b00_0000_0_0);
    endcase
  end

  assign shift_left   = (op_base == LSH) || (op_base == LRO);
  assign shift_rotate = (op_base == LRO) || (op_base == RRO);

  // ####################
  // operand select
  // ####################
  // rd and rs0 sit at the same bits in both layouts.
  assign rs0_addr_o = head_instr_i.reg_form.rs0;
  assign rs1_addr_o = head_instr_i.reg_form.rs1; // read is ignored for immediate forms.

  assign imm_ext = {{(DATA_WIDTH - IMM_WIDTH){1'b0}}, head_instr_i.imm_form.imm};

  // NOT takes only operand a, so b is tied to zero to let the OR path pass a through.
  always_comb begin
    if (op_base == NOT) begin
      opd_b = '0;
    end else if (is_imm) begin
      opd_b = imm_ext;
    end else begin
      opd_b = rs1_data_i;
    end
  end

  alu_comb #(
    .DATA_WIDTH(DATA_WIDTH)
  ) u_alu_comb (
    .a_i(rs0_data_i),
    .b_i(opd_b),
    .shamt_i(opd_b[3:0]),
    .shift_left_i(shift_left),
    .shift_rotate_i(shift_rotate),
    .ctrl_i(ctrl),
    .out_o(wr_data_o),
    .cout_o() // carry out is reserved for a future flags register.
  );

  // Writeback is valid whenever an instruction sits at the head.
  assign wr_valid_o = ~queue_empty_i;
  assign wr_addr_o  = head_instr_i.reg_form.rd;
  assign pop_o      = store_success_i; // advance once the result is stored.

endmodule

`default_nettype wire

// File: hw/exec_unit_top.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit_top import pkg_dtypes::*; #(
  parameter int DATA_WIDTH  = WORD_WIDTH,
  parameter int QUEUE_DEPTH = 4
) (
  input  wire                       clk,
  input  wire                       reset_i,

  input  wire                       push_i,
  input  wire type_iqueue_opcode    instr_i,
  output logic                      queue_full_o,

  input  wire                       wb_ready_i,
  output logic                      wb_valid_o,
  output logic [REG_ADDR_WIDTH-1:0] wb_addr_o,
  output logic [DATA_WIDTH-1:0]     wb_data_o
);

  type_iqueue_opcode         head_instr;
  logic                      queue_empty;
  logic                      pop;
  logic [REG_ADDR_WIDTH-1:0] rs0_addr;
  logic [REG_ADDR_WIDTH-1:0] rs1_addr;
  logic [DATA_WIDTH-1:0]     rs0_data;
  logic [DATA_WIDTH-1:0]     rs1_data;
  logic                      wr_valid;
  logic [REG_ADDR_WIDTH-1:0] wr_addr;
  logic [DATA_WIDTH-1:0]     wr_data;
  logic                      store_success;

  instr_queue #(
    .QUEUE_DEPTH(QUEUE_DEPTH)
  ) u_instr_queue (
    .clk(clk),
    .reset_i(reset_i),
    .push_i(push_i),
    .instr_i(instr_i),
    .pop_i(pop),
    .head_instr_o(head_instr),
    .empty_o(queue_empty),
    .full_o(queue_full_o)
  );

  alu #(
    .DATA_WIDTH(DATA_WIDTH)
  ) u_alu (
    .head_instr_i(head_instr),
    .queue_empty_i(queue_empty),
    .rs0_addr_o(rs0_addr),
    .rs1_addr_o(rs1_addr),
    .rs0_data_i(rs0_data),
    .rs1_data_i(rs1_data),
    .wr_valid_o(wr_valid),
    .wr_addr_o(wr_addr),
    .wr_data_o(wr_data),
    .store_success_i(store_success),
    .pop_o(pop)
  );

  reg_file #(
    .DATA_WIDTH(DATA_WIDTH)
  ) u_reg_file (
    .clk(clk),
    .reset_i(reset_i),
    .rs0_addr_i(rs0_addr),
    .rs1_addr_i(rs1_addr),
    .rs0_data_o(rs0_data),
    .rs1_data_o(rs1_data),
    .wr_valid_i(wr_valid),
    .wr_addr_i(wr_addr),
    .wr_data_i(wr_data),
    .wb_ready_i(wb_ready_i),
    .store_success_o(store_success)
  );

  // the retire port shows the pending writeback as is.
  assign wb_valid_o = wr_valid;
  assign wb_addr_o  = wr_addr;
  assign wb_data_o  = wr_data;

endmodule

`default_nettype wire

// File: testbench/tb_exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exec_unit import pkg_dtypes::*; ();

  localparam int DATA_WIDTH  = WORD_WIDTH;
  localparam int QUEUE_DEPTH = 4;
  localparam int CLK_PERIOD  = 40;
  localparam int HOLD_CYCLES = 8;
  localparam int IDLE_CYCLES = 6;
  localparam int N_LOADS     = 7;
  localparam int N_IMM_OPS   = 13;
  localparam int N_RAND      = 40;
  localparam int N_CHAIN     = 4;
  localparam int N_BP        = 3;
  localparam int N_FULL      = QUEUE_DEPTH + 1;
  localparam int N_PUSHES    = N_LOADS + N_IMM_OPS + N_RAND + N_CHAIN + N_BP + N_FULL;
  localparam int N_STALLS    = 4 + IDLE_CYCLES + 2 * HOLD_CYCLES + 20;

  logic                      clk;
  logic                      reset_i;
  logic                      push_i;
  logic [INSTR_WIDTH-1:0]    instr_i;
  logic                      queue_full_o;
  logic                      wb_ready_i;
  logic                      wb_valid_o;
  logic [REG_ADDR_WIDTH-1:0] wb_addr_o;
  logic [DATA_WIDTH-1:0]     wb_data_o;

  integer seed;
  int     mismatch_count = 0;
  int     other_count = 0;

  exec_unit_top #(
    .DATA_WIDTH(DATA_WIDTH),
    .QUEUE_DEPTH(QUEUE_DEPTH)
  ) DUT (
    .clk(clk),
    .reset_i(reset_i),
    .push_i(push_i),
    .instr_i(instr_i),
    .queue_full_o(queue_full_o),
    .wb_ready_i(wb_ready_i),
    .wb_valid_o(wb_valid_o),
    .wb_addr_o(wb_addr_o),
    .wb_data_o(wb_data_o)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // ####################
  // reference model
  // ####################
  logic [INSTR_WIDTH-1:0]    exp_instr [256]; // accepted words in push order.
  logic [7:0]                wr_idx;
  logic [7:0]                rd_idx;
  logic [7:0]                pending;
  logic [DATA_WIDTH-1:0]     model_regs [8];
  logic [INSTR_WIDTH-1:0]    head_word;
  logic [REG_ADDR_WIDTH-1:0] exp_addr;
  logic [DATA_WIDTH-1:0]     exp_data;
  logic                      push_accept;
  logic                      retire;

  // word layout: opcode [15:11], rd [10:8], rs0 [7:5], rs1 [4:2] or imm [4:0].
  function automatic logic [DATA_WIDTH-1:0] reference_result(
      input logic [INSTR_WIDTH-1:0] word, input logic [DATA_WIDTH-1:0] a,
      input logic [DATA_WIDTH-1:0] rs1_val);
    logic [DATA_WIDTH-1:0] b;
    logic [DATA_WIDTH-1:0] r;
    int                    sh;
    b  = word[15] ? DATA_WIDTH'(word[4:0]) : rs1_val;
    sh = int'(b[3:0]);
    case (word[14:11])
      4'h0: r = ~a;
      4'h1: r = a & b;
      4'h2: r = a | b;
      4'h3: r = a ^ b;
      4'h4: r = a + b;
      4'h5: r = a - b;
      4'h6: r = ~(a & b);
      4'h7: r = ~(a | b);
      4'h8: r = ~(a ^ b);
      4'h9: r = a << sh;
      4'ha: r = a >> sh;
      4'hb: r = (sh == 0) ? a : ((a << sh) | (a >> (DATA_WIDTH - sh)));
      4'hc: r = (sh == 0) ? a : ((a >> sh) | (a << (DATA_WIDTH - sh)));
      default: r = '0;
    endcase
    return r;
  endfunction

  assign pending     = wr_idx - rd_idx;
  assign push_accept = push_i && (pending != 8'(QUEUE_DEPTH)); // a full queue drops the word.
  assign retire      = (pending != 8'd0) && wb_ready_i;

  always_comb begin
    head_word = exp_instr[rd_idx];
    exp_addr  = head_word[10:8];
    exp_data  = reference_result(head_word, model_regs[head_word[7:5]],
                                 model_regs[head_word[4:2]]);
  end

  always @(posedge clk) begin
    if (reset_i) begin
      wr_idx <= '0;
      rd_idx <= '0;
      for (int i = 0; i < 8; i++) begin
        model_regs[i] <= '0;
      end
    end else begin
      if (push_accept) begin
        exp_instr[wr_idx] <= instr_i;
        wr_idx            <= wr_idx + 8'd1;
      end
      if (retire) begin
        model_regs[exp_addr] <= exp_data; // registers change only when a result retires.
        rd_idx               <= rd_idx + 8'd1;
      end
    end
  end

  // what the retire port showed in a cycle where the sink was not ready.
  logic                      held;
  logic [REG_ADDR_WIDTH-1:0] held_addr;
  logic [DATA_WIDTH-1:0]     held_data;

  always @(posedge clk) begin
    held      <= !reset_i && wb_valid_o && !wb_ready_i;
    held_addr <= wb_addr_o;
    held_data <= wb_data_o;
  end

  // ####################
  // assertions
  // ####################
  a_nothing_extra: assert property (@(posedge clk) disable iff (reset_i)
      (pending == 8'd0) |-> !wb_valid_o)
    else begin
      other_count++;
      $display("unexpected retirement: wb_valid_o is high with nothing outstanding");
    end

  a_nothing_missing: assert property (@(posedge clk) disable iff (reset_i)
      (pending != 8'd0) |-> wb_valid_o)
    else begin
      other_count++;
      $display("missing retirement: %0d instructions outstanding but wb_valid_o low", pending);
    end

  a_retire_addr: assert property (@(posedge clk) disable iff (reset_i)
      (retire && wb_valid_o) |-> (wb_addr_o == exp_addr))
    else begin
      mismatch_count++;
      $display("MISMATCH wb_addr_o expected %h got %h", exp_addr, wb_addr_o);
    end

  a_retire_data: assert property (@(posedge clk) disable iff (reset_i)
      (retire && wb_valid_o) |-> (wb_data_o == exp_data))
    else begin
      mismatch_count++;
      $display("MISMATCH wb_data_o expected %h got %h", exp_data, wb_data_o);
    end

  a_full_level: assert property (@(posedge clk) disable iff (reset_i)
      queue_full_o == (pending == 8'(QUEUE_DEPTH)))
    else begin
      mismatch_count++;
      $display("MISMATCH queue_full_o expected %h got %h",
               pending == 8'(QUEUE_DEPTH), queue_full_o);
    end

  a_hold_valid: assert property (@(posedge clk) disable iff (reset_i) held |-> wb_valid_o)
    else begin
      mismatch_count++;
      $display("MISMATCH wb_valid_o expected %h got %h", 1'b1, wb_valid_o);
    end

  a_hold_addr: assert property (@(posedge clk) disable iff (reset_i)
      held |-> (wb_addr_o == held_addr))
    else begin
      mismatch_count++;
      $display("MISMATCH wb_addr_o expected %h got %h", held_addr, wb_addr_o);
    end

  a_hold_data: assert property (@(posedge clk) disable iff (reset_i)
      held |-> (wb_data_o == held_data))
    else begin
      mismatch_count++;
      $display("MISMATCH wb_data_o expected %h got %h", held_data, wb_data_o);
    end

  // ####################
  // stimulus
  // ####################
  function automatic logic [INSTR_WIDTH-1:0] reg_word(input logic [4:0] op,
      input logic [2:0] rd, input logic [2:0] rs0, input logic [2:0] rs1);
    return {op, rd, rs0, rs1, 2'b00};
  endfunction

  function automatic logic [INSTR_WIDTH-1:0] imm_word(input logic [4:0] op,
      input logic [2:0] rd, input logic [2:0] rs0, input logic [4:0] imm);
    return {op, rd, rs0, imm};
  endfunction

  task automatic push_word(input logic [INSTR_WIDTH-1:0] word);
    @(posedge clk);
    push_i  <= 1'b1;
    instr_i <= word;
  endtask

  task automatic end_push();
    @(posedge clk);
    push_i <= 1'b0;
  endtask

  task automatic wait_drain(input int limit);
    int n;
    n = 0;
    @(negedge clk);
    while (pending != 8'd0 && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (pending != 8'd0) begin
      other_count++;
      $display("missing retirement: %0d still outstanding after %0d cycles", pending, limit);
    end
  endtask

  task automatic push_random_reg();
    logic [31:0] rnd;
    rnd = $random(seed);
    push_word(reg_word(5'(rnd[7:0] % 8'd13), rnd[10:8], rnd[13:11], rnd[16:14]));
  endtask

  initial begin
    logic [31:0] rnd;
    seed       = 32'hf88b_4d4b;
    reset_i    = 1'b1;
    push_i     = 1'b0;
    instr_i    = '0;
    wb_ready_i = 1'b1;
    repeat (4) @(posedge clk);
    reset_i <= 1'b0;

    repeat (IDLE_CYCLES) @(posedge clk); // idle after reset, nothing may retire.

    // load r1..r7 from the zeroed r0, then run every immediate operation.
    for (int k = 1; k <= N_LOADS; k++) begin
      rnd = $random(seed);
      push_word(imm_word(ADD_I, 3'(k), 3'd0, rnd[4:0]));
    end
    for (int k = 0; k < N_IMM_OPS; k++) begin
      rnd = $random(seed);
      push_word(imm_word(5'h10 | 5'(k), 3'(1 + k % 7), 3'(1 + (k + 3) % 7), rnd[4:0]));
    end
    end_push();
    wait_drain(N_LOADS + N_IMM_OPS + 10);

    for (int k = 0; k < N_RAND; k++) begin
      push_random_reg();
    end
    // a dependent chain, each word reads what the one before it wrote.
    push_word(reg_word(ADD, 3'd3, 3'd1, 3'd2));
    push_word(reg_word(SUB, 3'd4, 3'd3, 3'd1));
    push_word(reg_word(XOR, 3'd3, 3'd4, 3'd3));
    push_word(reg_word(LRO, 3'd5, 3'd3, 3'd4));
    end_push();
    wait_drain(N_RAND + N_CHAIN + 10);

    @(posedge clk);
    wb_ready_i <= 1'b0; // the sink stalls while words are queued.
    for (int k = 0; k < N_BP; k++) begin
      push_random_reg();
    end
    end_push();
    repeat (HOLD_CYCLES) @(posedge clk);
    wb_ready_i <= 1'b1;
    wait_drain(N_BP + 10);

    @(posedge clk);
    wb_ready_i <= 1'b0;
    for (int k = 0; k < N_FULL; k++) begin
      push_random_reg(); // the last one meets a full queue.
    end
    end_push();
    repeat (HOLD_CYCLES) @(posedge clk);
    wb_ready_i <= 1'b1;
    wait_drain(N_FULL + 10);

    repeat (4) @(posedge clk);
    $display("summary: %0d mismatches, %0d other errors", mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // ####################
  // watchdog
  // ####################
  initial begin
    #(CLK_PERIOD * (N_PUSHES + N_STALLS + 200));
    $display("timeout: the run did not finish in %0d cycles", N_PUSHES + N_STALLS + 200);
    $display("summary: %0d mismatches, %0d other errors", mismatch_count, other_count + 1);
    $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
hw/pkg_dtypes.sv
hw/instr_queue.sv
hw/reg_file.sv
hw/alu_comb.sv
hw/alu.sv
hw/exec_unit_top.sv
testbench/tb_exec_unit.sv

// File: Makefile
# Verilator build and run of the execution unit testbench.
# Every variable below can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= tb_exec_unit
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_TEXT ?= tests failed

BIN     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench, run it and write $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_TEXT)" $(LOG); then \
	  echo "result: FAIL, see $(LOG)"; exit 1; \
	elif [ $$status -ne 0 ]; then \
	  echo "result: FAIL, simulator exited with status $$status"; exit 1; \
	else \
	  echo "result: PASS"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
